// ==== Makefile ====
TOP = tb_mvp_ctrl_top
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): mvp_ctrl_top.f common/mvp_settings.svh common/mvp_pkg.sv src/*.sv sim/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f mvp_ctrl_top.f -Mdir $(OBJ) -o V$(TOP)

# exit status of the simulation is the result
run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

// ==== common/mvp_pkg.sv ====
/*
 * mvp control path types
 * host configuration words, transfer sizes, stage handshake
 * and the run sequencer states
 */

`include "mvp_settings.svh"

package mvp_pkg;

    // host side register and counters
    typedef logic [31:0] cfg_word_t;
    typedef logic [31:0] xfer_bytes_t;
    typedef logic [14:0] batch_cnt_t;
    typedef logic [31:0] cycle_cnt_t;
    typedef logic [`MVP_STAGE_W-1:0] stage_id_t;

    // 0 level, 1 col_size, 2 split, 3 index, 4 mat_len
    typedef logic [4:0] cfg_err_t;

    // job configuration as written by the host
    typedef struct packed {
        cfg_word_t command;
        cfg_word_t level;
        cfg_word_t col_size;
        cfg_word_t split;
        cfg_word_t index;
        cfg_word_t mat_len;
    } mvp_cfg_t;

    // four-phase request towards the stages
    typedef struct packed {
        logic      req;
        stage_id_t id;
    } stage_req_t;

    // registered transfer sizes
    typedef struct packed {
        xfer_bytes_t mat_bytes;
        xfer_bytes_t vec_bytes;
        batch_cnt_t  batches;
    } xfer_info_t;

    typedef enum logic [2:0] {
        idle, check, issue, wait_ack, wait_release, done
    } run_state_e;

endpackage

// ==== common/mvp_settings.svh ====
/*
 * mvp control path constants
 * stage count, legal ranges of the job configuration
 * and byte multipliers of the host transfers
 */
`ifndef MVP_SETTINGS_SVH
`define MVP_SETTINGS_SVH

// pipeline stages s0..s9
`define MVP_NUM_STAGES          10
`define MVP_STAGE_W             4

// legal configuration ranges
`define MVP_MAX_LEVEL           12
`define MVP_MAX_COL             16384
// row_size * col_size floor
`define MVP_MIN_ELEMS           8192
`define MVP_MAX_SPLIT           4

// bytes per mat_len unit and per split
`define MVP_MAT_BYTES_PER_LEN   32'h0001_8000
`define MVP_VEC_BYTES_PER_SPLIT 32'h0003_0000

`endif

// ==== mvp_ctrl_top.f ====
+incdir+common
common/mvp_pkg.sv
src/mvp_run_seq.sv
src/mvp_cfg_check.sv
src/mvp_xfer_size.sv
src/mvp_ctrl_top.sv
sim/tb_mvp_ctrl_top.sv

// ==== sim/mvp_cases.txt ====
# command level col_size split index mat_len exp_err delay, all hex
# exp_err bits: 0 level 1 col_size 2 split 3 index 4 mat_len, delay 0 is random
1 1 1000 1 1 2 00 1
1 c 4000 4 2 2000 00 0
1 3 400 2 10 1 00 3
0 0 0 0 0 12345 00 0
1 0 2000 1 1 1 01 2
1 2 4001 1 4 1 02 0
1 2 100 1 1 4 02 0
1 1 1000 0 1 0 04 0
1 4 200 5 8 a 04 0
1 1 1000 2 3 1 18 0
1 1 1000 1 2000 1 18 0
1 5 100 3 20 4 10 0
1 1 1000 1 1 8002 10 0
1 11 0 7 0 5 1f 0
2 1 1000 1 1 2 00 5
3 6 80 4 100 1 00 0
1 1 0 1 2 1 02 0
1 c 4000 1 1000 1 00 0
0 ffffffff ffffffff ffffffff ffffffff 7fff 00 7
1 a 8 1 1 400 00 0
1 1 1000 4 1 8 00 2
1 c 1 1 1 1000 02 0
1 2 800 2 1 8 00 0
0 1 1000 1 1 2 00 0
1 7 40 1 80 1 00 4
1 8 20 2 2 100 00 0

// ==== sim/tb_mvp_ctrl_top.sv ====
/*
 * testbench for the mvp host control path
 * jobs come from the case file, a responder answers the stage port,
 * flags, sizes, stage order and the busy counter are checked
 */

`timescale 1ns/10ps

`include "mvp_settings.svh"

module tb_mvp_ctrl_top;

    logic                clk;
    logic                rst_n;
    logic                i_ap_start;
    mvp_pkg::mvp_cfg_t   i_cfg;
    logic                i_stage_ack;
    logic                o_ap_idle;
    logic                o_ap_done;
    mvp_pkg::cfg_err_t   o_cfg_err;
    mvp_pkg::cycle_cnt_t o_cycle_cnt;
    mvp_pkg::xfer_info_t o_xfer;
    mvp_pkg::stage_req_t o_stage;

    // responder state and bookkeeping
    mvp_pkg::stage_id_t  ids[$];
    mvp_pkg::stage_id_t  cur_id;
    mvp_pkg::cycle_cnt_t busy_edges;
    logic [31:0]         rng;
    logic                req_prev;
    int                  hold;
    int                  case_delay;

    mvp_ctrl_top u_mvp_ctrl_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ap_start  (i_ap_start),
        .i_cfg       (i_cfg),
        .o_ap_idle   (o_ap_idle),
        .o_ap_done   (o_ap_done),
        .o_cfg_err   (o_cfg_err),
        .o_cycle_cnt (o_cycle_cnt),
        .o_xfer      (o_xfer),
        .o_stage     (o_stage),
        .i_stage_ack (i_stage_ack)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    //////////////////////////////////////////////////
    // compare tasks
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_err(input string name, input mvp_pkg::cfg_err_t got,
                             input mvp_pkg::cfg_err_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_xfer(input string name, input mvp_pkg::xfer_info_t got,
                              input mvp_pkg::xfer_info_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_id(input string name, input mvp_pkg::stage_id_t got,
                            input mvp_pkg::stage_id_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input mvp_pkg::cycle_cnt_t got,
                               input mvp_pkg::cycle_cnt_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    //////////////////////////////////////////////////
    // reference rules
    function automatic mvp_pkg::cfg_err_t rule_flags(input mvp_pkg::mvp_cfg_t c);
        mvp_pkg::cfg_err_t f;
        longint            rows;
        int                ones;
        int                b;
        f    = '0;
        rows = longint'(1) << c.level[3:0];
        ones = 0;
        for (b = 0; b < 13; b++)
            ones += int'(c.index[b]);
        // load-only jobs carry no flags
        if (c.command[0]) begin
            f[0] = (c.level == 0) || (c.level > `MVP_MAX_LEVEL);
            f[1] = (c.col_size == 0) || (c.col_size > `MVP_MAX_COL)
                   || (rows * c.col_size[14:0] < `MVP_MIN_ELEMS);
            f[2] = (c.split == 0) || (c.split > `MVP_MAX_SPLIT);
            f[3] = (c.index[31:13] != 0) || (ones != 1);
            f[4] = (c.mat_len[31:15] != 0)
                   || (c.mat_len[14:0] * c.index[12:0] != c.split[2:0] * rows);
        end
        return f;
    endfunction

    function automatic mvp_pkg::xfer_info_t rule_xfer(input mvp_pkg::mvp_cfg_t c);
        mvp_pkg::xfer_info_t x;
        x.mat_bytes = c.mat_len * `MVP_MAT_BYTES_PER_LEN;
        x.vec_bytes = 32'(c.split[2:0]) * `MVP_VEC_BYTES_PER_SPLIT;
        x.batches   = mvp_pkg::batch_cnt_t'(c.mat_len[14:1])
                      + mvp_pkg::batch_cnt_t'(c.split[2:0]);
        return x;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    //////////////////////////////////////////////////
    // stage responder, samples 1 ns and drives 2 ns after the edge
    always @(posedge clk) begin
        #1;
        if (rst_n) begin
            if (o_stage.req && !req_prev) begin
                if (i_stage_ack)
                    abort_run("stage req raised while ack was still high");
                ids.push_back(o_stage.id);
                cur_id = o_stage.id;
                rng    = lcg_next(rng);
                hold   = (case_delay != 0) ? case_delay : int'(rng[18:16]);
            end
            // id held for the whole request
            if (o_stage.req && req_prev)
                check_id("o_stage.id", o_stage.id, cur_id);
            if (o_stage.req && !i_stage_ack) begin
                if (hold == 0) begin
                    #1;
                    i_stage_ack = 1'b1;
                end else begin
                    hold = hold - 1;
                end
            end else if (!o_stage.req && i_stage_ack) begin
                #1;
                i_stage_ack = 1'b0;
            end
            req_prev = o_stage.req;
        end
    end

    // busy edges seen by the testbench vs the DUT counter
    always @(negedge clk)
        if (rst_n && !o_ap_idle)
            busy_edges = busy_edges + 1;

    always @(posedge clk) begin
        #1;
        if (rst_n)
            check_count("o_cycle_cnt", o_cycle_cnt, busy_edges);
    end

    //////////////////////////////////////////////////
    // job driver
    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (o_ap_done !== 1'b1) begin
            if (n == limit)
                abort_run("timeout while waiting for o_ap_done");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic run_case(input mvp_pkg::mvp_cfg_t c, input mvp_pkg::cfg_err_t exp,
                            input int dly);
        int n_exp;
        int i;
        n_exp = c.command[0] ? `MVP_NUM_STAGES : 1;
        check_err("case file flags vs rules", exp, rule_flags(c));
        @(posedge clk);
        #2;
        i_cfg      = c;
        case_delay = dly;
        @(posedge clk);
        #1;
        check_xfer("o_xfer", o_xfer, rule_xfer(c));
        check_flag("o_ap_idle", o_ap_idle, 1'b1);
        #1;
        i_ap_start = 1'b1;
        // edge E samples the start
        @(posedge clk);
        #2;
        i_ap_start = 1'b0;
        @(posedge clk);
        #1;
        check_err("o_cfg_err", o_cfg_err, exp);
        @(posedge clk);
        #1;
        check_flag("o_ap_idle", o_ap_idle, 1'b0);
        check_flag("o_ap_done", o_ap_done, 1'b0);
        if (|exp) begin
            @(posedge clk);
            #1;
            check_flag("o_ap_done", o_ap_done, 1'b1);
            n_exp = 0;
        end else begin
            // second start while busy, must be ignored
            #1;
            i_ap_start = 1'b1;
            @(posedge clk);
            #2;
            i_ap_start = 1'b0;
            wait_done(400);
        end
        check_flag("o_ap_idle", o_ap_idle, 1'b1);
        check_flag("o_stage.req", o_stage.req, 1'b0);
        if (ids.size() != n_exp)
            abort_run($sformatf("job issued %0d stage requests instead of %0d",
                                ids.size(), n_exp));
        for (i = 0; i < n_exp; i++)
            check_id("stage order", ids[i], mvp_pkg::stage_id_t'(i));
        ids.delete();
    endtask

    initial begin
        int                fd;
        int                n_cases;
        string             line;
        logic [31:0]       w_cmd, w_lvl, w_col, w_spl, w_idx, w_len, w_err, w_dly;
        mvp_pkg::mvp_cfg_t c;
        clk         = 1'b0;
        rst_n       = 1'b0;
        i_ap_start  = 1'b0;
        i_cfg       = '0;
        i_stage_ack = 1'b0;
        rng         = 32'he65d_4342;
        req_prev    = 1'b0;
        hold        = 0;
        case_delay  = 1;
        busy_edges  = '0;
        cur_id      = '0;
        n_cases     = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_flag("o_ap_idle", o_ap_idle, 1'b1);
        check_flag("o_ap_done", o_ap_done, 1'b0);
        check_flag("o_stage.req", o_stage.req, 1'b0);
        check_count("o_cycle_cnt", o_cycle_cnt, '0);
        fd = $fopen("sim/mvp_cases.txt", "r");
        if (fd == 0)
            abort_run("cannot open sim/mvp_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            if ($sscanf(line, "%h %h %h %h %h %h %h %h", w_cmd, w_lvl, w_col, w_spl,
                        w_idx, w_len, w_err, w_dly) != 8)
                abort_run($sformatf("bad line in case file: %s", line));
            c = '{w_cmd, w_lvl, w_col, w_spl, w_idx, w_len};
            run_case(c, mvp_pkg::cfg_err_t'(w_err), int'(w_dly));
            n_cases++;
        end
        $fclose(fd);
        if (n_cases == 0)
            abort_run("case file holds no jobs");
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== src/mvp_cfg_check.sv ====
/*
 * mvp configuration checker
 * validates level, col_size, split, index and mat_len of a run job
 * when a start is accepted and holds the five error flags
 */

`timescale 1ns/10ps

`include "mvp_settings.svh"

module mvp_cfg_check (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_accept,
    input  mvp_pkg::mvp_cfg_t i_cfg,
    output mvp_pkg::cfg_err_t o_cfg_err
);

    // row_size reaches 1 << 15 from the 4-bit level field
    logic [15:0]       row_size;
    logic [30:0]       elems;
    logic [27:0]       mat_span;
    logic [18:0]       split_rows;
    mvp_pkg::cfg_err_t err_next;

    assign row_size   = 16'd1 << i_cfg.level[3:0];
    assign elems      = row_size * i_cfg.col_size[14:0];
    // mat_len * index must cover split * row_size exactly
    assign mat_span   = i_cfg.mat_len[14:0] * i_cfg.index[12:0];
    assign split_rows = i_cfg.split[2:0] * row_size;

    //////////////////////////////////////////////////
    // flag rules
    always_comb begin
        // level
        err_next[0] = (i_cfg.level == '0) || (i_cfg.level > `MVP_MAX_LEVEL);
        // col_size range and element floor
        err_next[1] = (i_cfg.col_size == '0) || (i_cfg.col_size > `MVP_MAX_COL)
                      || (elems < `MVP_MIN_ELEMS);
        // split
        err_next[2] = (i_cfg.split == '0) || (i_cfg.split > `MVP_MAX_SPLIT);
        // index must be one-hot in [12:0]
        err_next[3] = (|i_cfg.index[31:13]) || ($countones(i_cfg.index[12:0]) != 1);
        // mat_len
        err_next[4] = (|i_cfg.mat_len[31:15]) || (mat_span != split_rows);
    end

    //////////////////////////////////////////////////
    // latch on accept and hold in between
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_cfg_err <= '0;
        end else if (i_accept) begin
            // load-only job is never rejected
            if (i_cfg.command[0])
                o_cfg_err <= err_next;
            else
                o_cfg_err <= '0;
        end
    end

endmodule

// ==== src/mvp_ctrl_top.sv ====
/*
 * mvp accelerator host control
 * start detection, configuration checks, transfer sizes
 * and sequencing of the external pipeline stages
 */

`timescale 1ns/10ps

module mvp_ctrl_top (
    input  logic                clk,
    input  logic                rst_n,
    // host control
    input  logic                i_ap_start,
    input  mvp_pkg::mvp_cfg_t   i_cfg,
    output logic                o_ap_idle,
    output logic                o_ap_done,
    output mvp_pkg::cfg_err_t   o_cfg_err,
    output mvp_pkg::cycle_cnt_t o_cycle_cnt,
    output mvp_pkg::xfer_info_t o_xfer,
    // stage handshake
    output mvp_pkg::stage_req_t o_stage,
    input  logic                i_stage_ack
);

    // accepted start, one cycle wide
    logic              accept;
    mvp_pkg::cfg_err_t cfg_err;

    //////////////////////////////////////////////////
    // sequencer
    mvp_run_seq u_run_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ap_start  (i_ap_start),
        .i_run_mvp   (i_cfg.command[0]),
        .i_cfg_err   (cfg_err),
        .i_stage_ack (i_stage_ack),
        .o_accept    (accept),
        .o_stage     (o_stage),
        .o_ap_idle   (o_ap_idle),
        .o_ap_done   (o_ap_done),
        .o_cycle_cnt (o_cycle_cnt)
    );

    //////////////////////////////////////////////////
    // configuration checks, latched on accept
    mvp_cfg_check u_cfg_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_accept  (accept),
        .i_cfg     (i_cfg),
        .o_cfg_err (cfg_err)
    );

    assign o_cfg_err = cfg_err;

    // sizes follow the live configuration
    mvp_xfer_size u_xfer_size (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_cfg  (i_cfg),
        .o_xfer (o_xfer)
    );

endmodule

// ==== src/mvp_run_seq.sv ====
/*
 * mvp run sequencer
 * detects the ap_start edge, walks the pipeline stages over
 * a four-phase req/ack port and counts busy cycles
 */

`timescale 1ns/10ps

`include "mvp_settings.svh"

module mvp_run_seq (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_ap_start,
    input  logic                i_run_mvp,
    input  mvp_pkg::cfg_err_t   i_cfg_err,
    input  logic                i_stage_ack,
    output logic                o_accept,
    output mvp_pkg::stage_req_t o_stage,
    output logic                o_ap_idle,
    output logic                o_ap_done,
    output mvp_pkg::cycle_cnt_t o_cycle_cnt
);

    mvp_pkg::run_state_e state;
    logic                ap_start_r;
    logic                accept_r;
    mvp_pkg::stage_id_t  last_id;

    // load-only job stops after stage 0
    assign last_id = i_run_mvp ? mvp_pkg::stage_id_t'(`MVP_NUM_STAGES - 1) : '0;

    //////////////////////////////////////////////////
    // start edge, taken only while idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ap_start_r <= 1'b0;
            accept_r   <= 1'b0;
        end else begin
            ap_start_r <= i_ap_start;
            accept_r   <= i_ap_start & ~ap_start_r & (state == mvp_pkg::idle);
        end
    end

    assign o_accept = accept_r;

    //////////////////////////////////////////////////
    // job state machine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mvp_pkg::idle;
            o_stage   <= '0;
            o_ap_idle <= 1'b1;
            o_ap_done <= 1'b0;
        end else begin
            case (state)
                mvp_pkg::idle: begin
                    if (accept_r)
                        state <= mvp_pkg::check;
                end
                // flags valid here, one cycle after accept
                mvp_pkg::check: begin
                    o_ap_idle <= 1'b0;
                    o_ap_done <= 1'b0;
                    if (|i_cfg_err) begin
                        state <= mvp_pkg::done;
                    end else begin
                        o_stage.id <= '0;
                        state      <= mvp_pkg::issue;
                    end
                end
                // id already stable, raise req
                mvp_pkg::issue: begin
                    o_stage.req <= 1'b1;
                    state       <= mvp_pkg::wait_ack;
                end
                mvp_pkg::wait_ack: begin
                    if (i_stage_ack) begin
                        o_stage.req <= 1'b0;
                        state       <= mvp_pkg::wait_release;
                    end
                end
                // stage must drop ack before next req
                mvp_pkg::wait_release: begin
                    if (!i_stage_ack) begin
                        if (o_stage.id == last_id) begin
                            state <= mvp_pkg::done;
                        end else begin
                            o_stage.id <= o_stage.id + 1'b1;
                            state      <= mvp_pkg::issue;
                        end
                    end
                end
                mvp_pkg::done: begin
                    o_ap_done <= 1'b1;
                    o_ap_idle <= 1'b1;
                    state     <= mvp_pkg::idle;
                end
                default: state <= mvp_pkg::idle;
            endcase
        end
    end

    // busy cycles, cleared by reset only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            o_cycle_cnt <= '0;
        else if (!o_ap_idle)
            o_cycle_cnt <= o_cycle_cnt + 1'b1;
    end

endmodule

// ==== src/mvp_xfer_size.sv ====
/*
 * mvp transfer sizes
 * registered matrix and vector byte counts and batch count
 * taken from the live host configuration
 */

`timescale 1ns/10ps

`include "mvp_settings.svh"

module mvp_xfer_size (
    input  logic                clk,
    input  logic                rst_n,
    input  mvp_pkg::mvp_cfg_t   i_cfg,
    output mvp_pkg::xfer_info_t o_xfer
);

    //////////////////////////////////////////////////
    // size products, one register stage
    // keeps the multipliers off the host register path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_xfer <= '0;
        end else begin
            // wraps at 32 bits like the host field
            o_xfer.mat_bytes <= i_cfg.mat_len * `MVP_MAT_BYTES_PER_LEN;
            o_xfer.vec_bytes <= i_cfg.split[2:0] * `MVP_VEC_BYTES_PER_SPLIT;
            // half of mat_len plus one batch per split
            o_xfer.batches   <= i_cfg.mat_len[14:1] + i_cfg.split[2:0];
        end
    end

endmodule
